// File: dram_ctrl_params.svh
`ifndef DRAM_CTRL_PARAMS_SVH
`define DRAM_CTRL_PARAMS_SVH

// data path.
`define DATA_WIDTH    8

// address field widths of one l2 request.
`define BANK_BITS     3
`define ROW_BITS      7
`define COL_BITS      3

// device geometry, one select line each.
`define NUM_OF_BANKS  8
`define NUM_OF_ROWS   128
`define NUM_OF_COLS   8

// request queue entries, power of two.
`define FIFO_DEPTH    4

`endif

// File: dram_ctrl_pkg.sv
`include "dram_ctrl_params.svh"

package dram_ctrl_pkg;

    typedef enum logic {
        L2_READ  = 1'b0,
        L2_WRITE = 1'b1
    } l2_op_e;

    // command code on the dram side.
    typedef enum logic [1:0] {
        CMD_ACT = 2'd0,
        CMD_RD  = 2'd1,
        CMD_WR  = 2'd2,
        CMD_PRE = 2'd3
    } dram_cmd_e;

    // tracker verdict for a bank and row.
    typedef enum logic [1:0] {
        ROW_HIT      = 2'd0,
        ROW_EMPTY    = 2'd1,
        ROW_CONFLICT = 2'd2
    } row_state_e;

    // 22-bit l2 instruction, op in the top bit.
    typedef struct packed {
        l2_op_e                 op;
        logic [`BANK_BITS-1:0]  bank;
        logic [`ROW_BITS-1:0]   row;
        logic [`COL_BITS-1:0]   col;
        logic [`DATA_WIDTH-1:0] data;
    } l2_req_t;

    // one-hot selects sent with each command.
    typedef struct packed {
        logic [`NUM_OF_BANKS-1:0] bank_sel;
        logic [`NUM_OF_ROWS-1:0]  row_sel;
        logic [`NUM_OF_COLS-1:0]  col_sel;
    } dram_sel_t;

endpackage

// File: l2_req_fifo.sv
`timescale 1ns/1ps
`include "dram_ctrl_params.svh"

module l2_req_fifo
    import dram_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    push,
    input  l2_req_t req_in,
    input  logic    pop,
    output l2_req_t head,
    output logic    empty,
    output logic    full
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    l2_req_t            mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push_ok;
    logic               pop_ok;

    assign push_ok = push && !full;  // a push while full is dropped.
    assign pop_ok  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(`FIFO_DEPTH));
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth.
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage.
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= req_in;
        end
    end

endmodule

// File: dram_bank_tracker.sv
`timescale 1ns/1ps
`include "dram_ctrl_params.svh"

module dram_bank_tracker
    import dram_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`BANK_BITS-1:0] lookup_bank,
    input  logic [`ROW_BITS-1:0]  lookup_row,
    input  logic                  open_en,
    input  logic                  close_en,
    input  logic [`BANK_BITS-1:0] upd_bank,
    input  logic [`ROW_BITS-1:0]  upd_row,
    output row_state_e            row_state
);

    logic [`NUM_OF_BANKS-1:0] bank_open;
    logic [`ROW_BITS-1:0]     open_row [`NUM_OF_BANKS];

    // open flags, all banks closed out of reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_open <= '0;
        end else if (open_en) begin
            bank_open[upd_bank] <= 1'b1;
        end else if (close_en) begin
            bank_open[upd_bank] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (open_en) begin
            open_row[upd_bank] <= upd_row;
        end
    end

    // verdict is combinational.
    always_comb begin
        if (!bank_open[lookup_bank]) begin
            row_state = ROW_EMPTY;
        end else if (open_row[lookup_bank] == lookup_row) begin
            row_state = ROW_HIT;
        end else begin
            row_state = ROW_CONFLICT;  // other row open, needs pre.
        end
    end

endmodule

// File: dram_fsm.sv
`timescale 1ns/1ps
`include "dram_ctrl_params.svh"

module dram_fsm
    import dram_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  l2_req_t                head,
    input  logic                   empty,
    input  row_state_e             row_state,
    input  logic                   cmd_ack,
    input  logic [`DATA_WIDTH-1:0] dram_rdata,
    output logic                   pop,
    output logic [`BANK_BITS-1:0]  lookup_bank,
    output logic [`ROW_BITS-1:0]   lookup_row,
    output logic                   open_en,
    output logic                   close_en,
    output logic [`BANK_BITS-1:0]  upd_bank,
    output logic [`ROW_BITS-1:0]   upd_row,
    output logic                   cmd_req,
    output dram_cmd_e              cmd,
    output dram_sel_t              sel,
    output logic [`DATA_WIDTH-1:0] dram_wdata,
    output logic                   l2_rsp_valid,
    output logic [`DATA_WIDTH-1:0] l2_rsp_data
);

    typedef enum logic [2:0] {
        IDLE,
        PLAN,
        ISSUE,
        WAIT_ACK,
        WAIT_RELEASE,
        RESPOND
    } state_e;

    state_e    state_q;
    state_e    state_d;
    l2_req_t   req_q;
    dram_cmd_e next_cmd;
    logic      ack_seen;

    // request under service drives the tracker and the write data.
    assign lookup_bank = req_q.bank;
    assign lookup_row  = req_q.row;
    assign upd_bank    = req_q.bank;
    assign upd_row     = req_q.row;
    assign dram_wdata  = req_q.data;

    assign pop      = (state_q == IDLE) && !empty;
    assign ack_seen = (state_q == WAIT_ACK) && cmd_ack;
    assign open_en  = ack_seen && (cmd == CMD_ACT);
    assign close_en = ack_seen && (cmd == CMD_PRE);

    assign l2_rsp_valid = (state_q == RESPOND);

    // open-page rule. pre, then act, then the access.
    always_comb begin
        case (row_state)
            ROW_CONFLICT: next_cmd = CMD_PRE;
            ROW_EMPTY:    next_cmd = CMD_ACT;
            default:      next_cmd = (req_q.op == L2_WRITE) ? CMD_WR : CMD_RD;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!empty) begin
                    state_d = PLAN;
                end
            end
            PLAN:     state_d = ISSUE;
            ISSUE:    state_d = WAIT_ACK;
            WAIT_ACK: begin
                if (cmd_ack) begin
                    state_d = WAIT_RELEASE;
                end
            end
            WAIT_RELEASE: begin
                if (!cmd_ack) begin
                    if (cmd == CMD_RD) begin
                        state_d = RESPOND;
                    end else if (cmd == CMD_WR) begin
                        state_d = IDLE;
                    end else begin
                        state_d = PLAN;  // re-plan after pre or act.
                    end
                end
            end
            RESPOND:  state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            cmd_req <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ISSUE) begin
                cmd_req <= 1'b1;
            end else if (ack_seen) begin
                cmd_req <= 1'b0;  // drop one cycle after ack.
            end
        end
    end

    // payload registers.
    always_ff @(posedge clk) begin
        if (pop) begin
            req_q <= head;
        end
        if (state_q == PLAN) begin
            cmd          <= next_cmd;
            sel.bank_sel <= {{(`NUM_OF_BANKS-1){1'b0}}, 1'b1} << req_q.bank;
            sel.row_sel  <= {{(`NUM_OF_ROWS-1){1'b0}}, 1'b1} << req_q.row;
            sel.col_sel  <= {{(`NUM_OF_COLS-1){1'b0}}, 1'b1} << req_q.col;
        end
        if (ack_seen && (cmd == CMD_RD)) begin
            l2_rsp_data <= dram_rdata;  // valid while ack is high.
        end
    end

endmodule

// File: dram_ctrl.sv
`timescale 1ns/1ps
`include "dram_ctrl_params.svh"

module dram_ctrl
    import dram_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     l2_req,
    input  l2_req_t                  l2_req_instr,
    input  logic                     cmd_ack,
    input  logic [`DATA_WIDTH-1:0]   dram_rdata,
    output logic                     l2_req_full,
    output logic                     l2_rsp_valid,
    output logic [`DATA_WIDTH-1:0]   l2_rsp_data,
    output logic                     cmd_req,
    output dram_cmd_e                cmd,
    output logic [`NUM_OF_BANKS-1:0] bank_sel,
    output logic [`NUM_OF_ROWS-1:0]  row_sel,
    output logic [`NUM_OF_COLS-1:0]  col_sel,
    output logic [`DATA_WIDTH-1:0]   dram_wdata
);

    l2_req_t               fifo_head;
    logic                  fifo_empty;
    logic                  fifo_pop;
    logic [`BANK_BITS-1:0] lookup_bank;
    logic [`ROW_BITS-1:0]  lookup_row;
    row_state_e            row_state;
    logic                  open_en;
    logic                  close_en;
    logic [`BANK_BITS-1:0] upd_bank;
    logic [`ROW_BITS-1:0]  upd_row;
    dram_sel_t             sel;

    assign bank_sel = sel.bank_sel;
    assign row_sel  = sel.row_sel;
    assign col_sel  = sel.col_sel;

    l2_req_fifo u_fifo (
        .clk    (clk),
        .reset  (reset),
        .push   (l2_req),
        .req_in (l2_req_instr),
        .pop    (fifo_pop),
        .head   (fifo_head),
        .empty  (fifo_empty),
        .full   (l2_req_full)
    );

    dram_bank_tracker u_tracker (
        .clk         (clk),
        .reset       (reset),
        .lookup_bank (lookup_bank),
        .lookup_row  (lookup_row),
        .open_en     (open_en),
        .close_en    (close_en),
        .upd_bank    (upd_bank),
        .upd_row     (upd_row),
        .row_state   (row_state)
    );

    dram_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .head         (fifo_head),
        .empty        (fifo_empty),
        .row_state    (row_state),
        .cmd_ack      (cmd_ack),
        .dram_rdata   (dram_rdata),
        .pop          (fifo_pop),
        .lookup_bank  (lookup_bank),
        .lookup_row   (lookup_row),
        .open_en      (open_en),
        .close_en     (close_en),
        .upd_bank     (upd_bank),
        .upd_row      (upd_row),
        .cmd_req      (cmd_req),
        .cmd          (cmd),
        .sel          (sel),
        .dram_wdata   (dram_wdata),
        .l2_rsp_valid (l2_rsp_valid),
        .l2_rsp_data  (l2_rsp_data)
    );

endmodule

// File: dram_bfm.sv
`timescale 1ns/1ps
`include "dram_ctrl_params.svh"

module dram_bfm
    import dram_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cmd_req,
    input  dram_cmd_e                cmd,
    input  logic [`NUM_OF_BANKS-1:0] bank_sel,
    input  logic [`NUM_OF_ROWS-1:0]  row_sel,
    input  logic [`NUM_OF_COLS-1:0]  col_sel,
    input  logic [`DATA_WIDTH-1:0]   dram_wdata,
    input  logic [2:0]               ack_delay,
    input  logic [2:0]               rel_delay,
    output logic                     cmd_ack,
    output logic [`DATA_WIDTH-1:0]   dram_rdata
);

    localparam int MEM_WORDS = `NUM_OF_BANKS * `NUM_OF_ROWS * `NUM_OF_COLS;

    typedef enum logic [1:0] {B_IDLE, B_DELAY, B_HOLD, B_RELEASE} bfm_state_e;

    bfm_state_e             state;
    logic [2:0]             count;
    logic [`DATA_WIDTH-1:0] mem [MEM_WORDS];
    int                     addr;

    // position of the set bit.
    function automatic int onehot_to_id(input logic [`NUM_OF_ROWS-1:0] sel_bits);
        int id;
        id = 0;
        for (int i = 0; i < `NUM_OF_ROWS; i++) begin
            if (sel_bits[i]) begin
                id = i;
            end
        end
        return id;
    endfunction

    always_comb begin
        addr = onehot_to_id(`NUM_OF_ROWS'(bank_sel)) * `NUM_OF_ROWS + onehot_to_id(row_sel);
        addr = addr * `NUM_OF_COLS + onehot_to_id(`NUM_OF_ROWS'(col_sel));
    end

    always @(posedge clk) begin
        if (reset) begin
            state      <= B_IDLE;
            count      <= '0;
            cmd_ack    <= 1'b0;
            dram_rdata <= '0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                B_IDLE: begin
                    if (cmd_req) begin
                        count <= ack_delay;
                        state <= B_DELAY;
                    end
                end
                B_DELAY: begin
                    if (count <= 3'd1) begin
                        cmd_ack <= 1'b1;
                        state   <= B_HOLD;
                        if (cmd == CMD_WR) begin
                            mem[addr] <= dram_wdata;
                        end
                        if (cmd == CMD_RD) begin
                            dram_rdata <= mem[addr];  // held while ack is high.
                        end
                    end else begin
                        count <= count - 3'd1;
                    end
                end
                B_HOLD: begin
                    if (!cmd_req) begin
                        count <= rel_delay;
                        state <= B_RELEASE;
                    end
                end
                default: begin
                    if (count <= 3'd1) begin
                        cmd_ack <= 1'b0;
                        state   <= B_IDLE;
                    end else begin
                        count <= count - 3'd1;
                    end
                end
            endcase
        end
    end

endmodule

// File: dram_ctrl_assert.sv
`timescale 1ns/1ps
`include "dram_ctrl_params.svh"

module dram_ctrl_assert
    import dram_ctrl_pkg::*;
(
    input logic                     clk,
    input logic                     reset,
    input logic                     l2_req,
    input logic                     l2_req_full,
    input logic                     cmd_req,
    input logic                     cmd_ack,
    input dram_cmd_e                cmd,
    input logic [`NUM_OF_BANKS-1:0] bank_sel,
    input logic [`NUM_OF_ROWS-1:0]  row_sel,
    input logic [`NUM_OF_COLS-1:0]  col_sel
);

    int fail_count = 0;  // summed into the testbench verdict.

    req_held: assert property (@(posedge clk) disable iff (reset)
        cmd_req && !cmd_ack |=> cmd_req)
        else begin
            $error("cmd_req dropped before cmd_ack");
            fail_count++;
        end

    cmd_stable: assert property (@(posedge clk) disable iff (reset)
        cmd_req |=> !cmd_req || ($stable(cmd) && $stable(bank_sel)
            && $stable(row_sel) && $stable(col_sel)))
        else begin
            $error("command or selects changed while cmd_req high");
            fail_count++;
        end

    // four-phase, previous ack must be gone.
    no_req_on_ack: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_req) |-> !cmd_ack)
        else begin
            $error("cmd_req raised while cmd_ack still high");
            fail_count++;
        end

    sel_onehot: assert property (@(posedge clk) disable iff (reset)
        cmd_req |-> $onehot(bank_sel) && $onehot(row_sel) && $onehot(col_sel))
        else begin
            $error("select not one-hot during a command");
            fail_count++;
        end

    no_push_full: assert property (@(posedge clk) disable iff (reset)
        l2_req |-> !l2_req_full)
        else begin
            $error("request pushed while the queue is full");
            fail_count++;
        end

endmodule

bind dram_ctrl dram_ctrl_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .l2_req      (l2_req),
    .l2_req_full (l2_req_full),
    .cmd_req     (cmd_req),
    .cmd_ack     (cmd_ack),
    .cmd         (cmd),
    .bank_sel    (bank_sel),
    .row_sel     (row_sel),
    .col_sel     (col_sel)
);

// File: dram_ctrl_top_tb.sv
`timescale 1ns/1ps
`include "dram_ctrl_params.svh"

module dram_ctrl_top_tb
    import dram_ctrl_pkg::*;
();

    localparam int NUM_REQS     = 40;
    localparam int SLOW_FROM    = 28;  // slowest ack from here on.
    localparam int MAX_CMDS     = 3 * NUM_REQS;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int WATCHDOG_NS  = NUM_REQS * 40 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
    localparam int MEM_WORDS    = `NUM_OF_BANKS * `NUM_OF_ROWS * `NUM_OF_COLS;
    localparam int NUM_TESTS    = 5;
    localparam int T_RESET      = 0;
    localparam int T_SEQ        = 1;
    localparam int T_SEL        = 2;
    localparam int T_DATA       = 3;
    localparam int T_BP         = 4;

    logic                     clk;
    logic                     reset;
    logic                     l2_req;
    l2_req_t                  l2_req_instr;
    logic                     cmd_ack;
    logic [`DATA_WIDTH-1:0]   dram_rdata;
    logic                     l2_req_full;
    logic                     l2_rsp_valid;
    logic [`DATA_WIDTH-1:0]   l2_rsp_data;
    logic                     cmd_req;
    dram_cmd_e                cmd;
    logic [`NUM_OF_BANKS-1:0] bank_sel;
    logic [`NUM_OF_ROWS-1:0]  row_sel;
    logic [`NUM_OF_COLS-1:0]  col_sel;
    logic [`DATA_WIDTH-1:0]   dram_wdata;
    logic [2:0]               ack_delay;
    logic [2:0]               rel_delay;

    logic [15:0]              lfsr = 16'd64;
    logic                     slow_phase = 1'b0;
    logic                     req_seen = 1'b0;
    logic                     full_seen = 1'b0;
    l2_req_t                  stim [NUM_REQS];
    logic [2:0]               ack_table [MAX_CMDS];
    logic [2:0]               rel_table [MAX_CMDS];
    logic                     model_open [`NUM_OF_BANKS];
    logic [`ROW_BITS-1:0]     model_row [`NUM_OF_BANKS];
    logic [`DATA_WIDTH-1:0]   model_mem [MEM_WORDS];
    dram_cmd_e                exp_cmd_q [$];
    l2_req_t                  exp_req_q [$];
    logic [`DATA_WIDTH-1:0]   exp_data_q [$];
    int                       model_cmds = 0;
    int                       model_reads = 0;
    int                       cmd_count = 0;
    int                       rsp_count = 0;
    int                       row_kinds [3] = '{0, 0, 0};  // hit, empty, conflict.
    int                       checks [NUM_TESTS] = '{0, 0, 0, 0, 0};
    int                       errors [NUM_TESTS] = '{0, 0, 0, 0, 0};
    string                    test_names [NUM_TESTS] =
        '{"reset", "cmd_sequence", "selects", "read_data", "back_pressure"};

    dram_ctrl DUT (
        .clk (clk), .reset (reset), .l2_req (l2_req), .l2_req_instr (l2_req_instr),
        .cmd_ack (cmd_ack), .dram_rdata (dram_rdata), .l2_req_full (l2_req_full),
        .l2_rsp_valid (l2_rsp_valid), .l2_rsp_data (l2_rsp_data), .cmd_req (cmd_req),
        .cmd (cmd), .bank_sel (bank_sel), .row_sel (row_sel), .col_sel (col_sel),
        .dram_wdata (dram_wdata)
    );

    dram_bfm u_dram (
        .clk (clk), .reset (reset), .cmd_req (cmd_req), .cmd (cmd), .bank_sel (bank_sel),
        .row_sel (row_sel), .col_sel (col_sel), .dram_wdata (dram_wdata),
        .ack_delay (ack_delay), .rel_delay (rel_delay), .cmd_ack (cmd_ack),
        .dram_rdata (dram_rdata)
    );

    // galois lfsr, taps 16,14,13,11.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic build_stimulus();
        for (int n = 0; n < NUM_REQS; n++) begin
            stim[n].op   = (rand_bits(1) == 32'd1) ? L2_WRITE : L2_READ;
            stim[n].bank = `BANK_BITS'(rand_bits(2));  // few banks and rows give hits.
            stim[n].row  = `ROW_BITS'(rand_bits(2) * 37);
            stim[n].col  = `COL_BITS'(rand_bits(3));
            stim[n].data = `DATA_WIDTH'(rand_bits(8));
        end
        for (int n = 0; n < MAX_CMDS; n++) begin
            ack_table[n] = 3'(rand_bits(2) + 1);
            rel_table[n] = 3'(rand_bits(1) + 1);
        end
    endtask

    task automatic check_value(input int test, input logic [127:0] exp_v,
                               input logic [127:0] act_v);
        checks[test]++;
        assert (act_v === exp_v) else begin
            $display("[ERROR] %s: expected %0h, actual %0h", test_names[test], exp_v, act_v);
            errors[test]++;
        end
    endtask

    task automatic check_true(input int test, input bit cond, input string what);
        checks[test]++;
        assert (cond) else begin
            $display("%s: %s", test_names[test], what);
            errors[test]++;
        end
    endtask

    task automatic check_reset_outputs();
        check_value(T_RESET, 128'(1'b0), 128'(cmd_req));
        check_value(T_RESET, 128'(1'b0), 128'(l2_rsp_valid));
        check_value(T_RESET, 128'(1'b0), 128'(l2_req_full));
    endtask

    // open-page rule applied in request order.
    task automatic model_request(input l2_req_t r);
        int addr;
        addr = (int'(r.bank) * `NUM_OF_ROWS + int'(r.row)) * `NUM_OF_COLS + int'(r.col);
        if (!model_open[r.bank]) begin
            row_kinds[1]++;
        end else if (model_row[r.bank] == r.row) begin
            row_kinds[0]++;
        end else begin
            row_kinds[2]++;
            exp_cmd_q.push_back(CMD_PRE);
            exp_req_q.push_back(r);
            model_cmds++;
            model_open[r.bank] = 1'b0;
        end
        if (!model_open[r.bank]) begin
            exp_cmd_q.push_back(CMD_ACT);
            exp_req_q.push_back(r);
            model_cmds++;
            model_open[r.bank] = 1'b1;
            model_row[r.bank]  = r.row;
        end
        exp_cmd_q.push_back((r.op == L2_WRITE) ? CMD_WR : CMD_RD);
        exp_req_q.push_back(r);
        model_cmds++;
        if (r.op == L2_WRITE) begin
            model_mem[addr] = r.data;
        end else begin
            exp_data_q.push_back(model_mem[addr]);
            model_reads++;
        end
    endtask

    task automatic check_command();
        dram_cmd_e c;
        l2_req_t   r;
        check_true(T_SEQ, exp_cmd_q.size() != 0, "command issued with no request pending");
        if (exp_cmd_q.size() != 0) begin
            c = exp_cmd_q.pop_front();
            r = exp_req_q.pop_front();
            check_value(T_SEQ, 128'(c), 128'(cmd));
            check_value(T_SEL, 128'(1) << r.bank, 128'(bank_sel));
            check_value(T_SEL, 128'(1) << r.row, 128'(row_sel));
            check_value(T_SEL, 128'(1) << r.col, 128'(col_sel));
            if (c == CMD_WR) begin
                check_value(T_SEL, 128'(r.data), 128'(dram_wdata));
            end
        end
        ack_delay <= slow_phase ? 3'd4 : ack_table[cmd_count % MAX_CMDS];
        rel_delay <= slow_phase ? 3'd2 : rel_table[cmd_count % MAX_CMDS];
        cmd_count++;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (cmd_req && !req_seen) begin
                check_command();
            end
            if (l2_rsp_valid) begin
                check_true(T_DATA, exp_data_q.size() != 0, "response with no read pending");
                if (exp_data_q.size() != 0) begin
                    check_value(T_DATA, 128'(exp_data_q.pop_front()), 128'(l2_rsp_data));
                end
                rsp_count++;
            end
            if (slow_phase && l2_req_full) begin
                full_seen = 1'b1;
            end
        end
        req_seen = cmd_req;
    end

    task automatic report_test(input int test);
        $display("test %s: checks %0d, errors %0d", test_names[test], checks[test],
                 errors[test]);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int total_errors;
        int assert_fails;
        reset        = 1'b1;
        l2_req       = 1'b0;
        l2_req_instr = '0;
        ack_delay    = 3'd2;
        rel_delay    = 3'd1;
        for (int i = 0; i < `NUM_OF_BANKS; i++) begin
            model_open[i] = 1'b0;
            model_row[i]  = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        build_stimulus();

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_reset_outputs();  // first edge leaves x behind it.
            end
            if (i == RESET_CYCLES - 1) begin
                reset <= 1'b0;
            end
        end
        repeat (2) begin
            @(posedge clk);
            check_reset_outputs();
        end
        report_test(T_RESET);

        for (int n = 0; n < NUM_REQS; n++) begin
            @(posedge clk);
            while (l2_req_full) begin
                @(posedge clk);
            end
            if (n == SLOW_FROM) begin
                slow_phase <= 1'b1;
            end
            l2_req       <= 1'b1;
            l2_req_instr <= stim[n];
            model_request(stim[n]);
            @(posedge clk);
            l2_req <= 1'b0;
        end

        // drain until every command and read has been seen.
        while (exp_cmd_q.size() != 0 || exp_data_q.size() != 0 || cmd_req || cmd_ack) begin
            @(posedge clk);
        end
        @(posedge clk);

        check_true(T_SEQ, row_kinds[0] > 0, "no row hit was exercised");
        check_true(T_SEQ, row_kinds[1] > 0, "no closed bank was exercised");
        check_true(T_SEQ, row_kinds[2] > 0, "no row conflict was exercised");
        check_true(T_BP, full_seen, "queue never filled with the slowest acknowledge");
        check_value(T_BP, 128'(model_cmds), 128'(cmd_count));
        check_value(T_BP, 128'(model_reads), 128'(rsp_count));
        report_test(T_SEQ);
        report_test(T_SEL);
        report_test(T_DATA);
        report_test(T_BP);

        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_errors += errors[t];
        end
        assert_fails = DUT.u_assert.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 NUM_TESTS, checks[0] + checks[1] + checks[2] + checks[3] + checks[4],
                 total_errors, assert_fails);
        if (total_errors == 0 && assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: dram_ctrl.f
+incdir+.
dram_ctrl_pkg.sv
l2_req_fifo.sv
dram_bank_tracker.sv
dram_fsm.sv
dram_ctrl.sv
dram_bfm.sv
dram_ctrl_assert.sv
dram_ctrl_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dram_ctrl testbench with verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module dram_ctrl_top_tb -f dram_ctrl.f -o sim_dram_ctrl
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# keep running after an assertion error so the summary is printed.
./obj_dir/sim_dram_ctrl +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation clean, see $LOG"
exit 0
